// ==== genbus.f ====
rtl/genbus_pkg.sv
rtl/clock_enables.sv
rtl/sound_ram.sv
rtl/main_bus_arbiter.sv
rtl/sound_bus_arbiter.sv
rtl/genbus_top.sv
verification/genbus_chk.sv
verification/genbus_tb.sv

// ==== Bender.yml ====
package:
  name: genbus

sources:
  - rtl/genbus_pkg.sv
  - rtl/clock_enables.sv
  - rtl/sound_ram.sv
  - rtl/main_bus_arbiter.sv
  - rtl/sound_bus_arbiter.sv
  - rtl/genbus_top.sv
  - target: test
    files:
      - verification/genbus_chk.sv
      - verification/genbus_tb.sv

// ==== verification/genbus_tb.sv ====
/*
 * System bus controller testbench
 * Clock and reset, ROM and work RAM models, main CPU and sound
 * CPU bus cycle tasks, directed tests and the closing result
 */
`default_nettype none

module genbus_tb;

	localparam int WAIT_LIMIT = 200;

	logic                                MCLK;
	logic                                reset;
	logic [genbus_pkg::MBUS_ADDR_W:1]    m68k_addr;
	logic [genbus_pkg::MBUS_DATA_W-1:0]  m68k_wdata;
	logic                                m68k_as_n;
	logic                                m68k_uds_n;
	logic                                m68k_lds_n;
	logic                                m68k_rnw;
	wire  [genbus_pkg::MBUS_DATA_W-1:0]  m68k_rdata;
	wire                                 m68k_dtack_n;
	logic [15:0]                         z80_addr;
	logic [7:0]                          z80_wdata;
	logic                                z80_mreq_n;
	logic                                z80_rd_n;
	logic                                z80_wr_n;
	logic                                z80_busak_n;
	wire  [7:0]                          z80_rdata;
	wire                                 z80_wait_n;
	wire                                 z80_busrq_n;
	wire                                 z80_reset_n;
	wire  [genbus_pkg::MBUS_ADDR_W:1]    va;
	wire  [genbus_pkg::MBUS_DATA_W-1:0]  vdo;
	logic [genbus_pkg::MBUS_DATA_W-1:0]  vdi = 16'h0000;
	wire                                 rnw;
	wire                                 uds_n;
	wire                                 lds_n;
	wire                                 ram_ce_n;
	wire                                 rom_n;
	logic                                rom_dtack_n = 1'b1;
	logic                                ram_rdy = 1'b1;
	wire                                 m68k_ce_p;
	wire                                 m68k_ce_n;
	wire                                 z80_ce;

	int          errors;
	int          last_latency;
	logic [31:0] lfsr_state = 32'h2312_41e1;
	logic [15:0] open_bus_exp;
	logic [15:0] ram_model [0:255];
	int          rom_delay = 0;
	int          ram_phase = 0;

	genbus_top genbus_top_inst (.*);

	initial begin
		MCLK = 1'b0;
		forever #5 MCLK = ~MCLK;
	end

	// ------------------------------------------------
	// ROM and work RAM models
	// ------------------------------------------------
	// Low 16 address bits inverted
	function automatic logic [15:0] rom_word(input logic [23:0] byte_addr);
		return ~{byte_addr[15:1], 1'b0};
	endfunction

	always @(negedge MCLK) begin
		if (rom_n) begin
			rom_delay   <= 0;
			rom_dtack_n <= 1'b1;
		end else if (rom_delay == 3) begin
			rom_dtack_n <= 1'b0;
			vdi         <= rom_word({va, 1'b0});
		end else
			rom_delay <= rom_delay + 1;

		// RAM takes the access, then flags read data two cycles on
		if (ram_ce_n) begin
			ram_phase <= 0;
			ram_rdy   <= 1'b1;
		end else begin
			case (ram_phase)
				0: begin
					ram_rdy <= 1'b0;
					if (!rnw && !uds_n)
						ram_model[va[8:1]][15:8] <= vdo[15:8];
					if (!rnw && !lds_n)
						ram_model[va[8:1]][7:0] <= vdo[7:0];
				end
				2: begin
					ram_rdy <= 1'b1;
					vdi     <= ram_model[va[8:1]];
				end
				default: ;
			endcase
			if (ram_phase < 3)
				ram_phase <= ram_phase + 1;
		end
	end

	// ------------------------------------------------
	// Helpers
	// ------------------------------------------------
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic take_bits(input int count, output logic [15:0] value);
		value = '0;
		for (int i = 0; i < count; i++) begin
			value      = {value[14:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	function automatic logic [7:0] lane_byte(input logic [15:0] word, input logic odd);
		return odd ? word[7:0] : word[15:8];
	endfunction

	task automatic report_error(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		errors++;
		$display("Error at time %0t: %s, got %0h, expected %0h", $time, what, got, exp);
	endtask

	task automatic abort_run(input string why);
		$display("Timeout at time %0t: %s", $time, why);
		$display("TESTS FAILED");
		$finish;
	endtask

	// One main CPU cycle, lanes is {upper, lower}
	task automatic m68k_access(input logic [23:0] addr, input logic [15:0] wdata,
		input logic write, input logic [1:0] lanes,
		output logic [15:0] rdata, output logic [23:1] va_seen);
		int n;
		@(negedge MCLK);
		m68k_addr  = addr[23:1];
		m68k_wdata = wdata;
		m68k_rnw   = ~write;
		m68k_uds_n = ~lanes[1];
		m68k_lds_n = ~lanes[0];
		m68k_as_n  = 1'b0;
		n = 0;
		do begin
			@(negedge MCLK);
			n++;
		end while (m68k_dtack_n && n < WAIT_LIMIT);
		if (m68k_dtack_n)
			abort_run("main CPU cycle never got dtack");
		last_latency = n;
		rdata        = m68k_rdata;
		va_seen      = va;
		m68k_as_n    = 1'b1;
		m68k_uds_n   = 1'b1;
		m68k_lds_n   = 1'b1;
		m68k_rnw     = 1'b1;
		n = 0;
		do begin
			@(negedge MCLK);
			n++;
		end while (!m68k_dtack_n && n < WAIT_LIMIT);
		if (!m68k_dtack_n)
			abort_run("dtack stayed low after the address strobe rose");
		if (n != 1)
			report_error("dtack release delay", n, 1);
	endtask

	task automatic z80_access(input logic [15:0] addr, input logic [7:0] wdata,
		input logic read, output logic [7:0] rdata, output logic [23:1] va_seen);
		int n;
		@(negedge MCLK);
		z80_addr   = addr;
		z80_wdata  = wdata;
		z80_rd_n   = ~read;
		z80_wr_n   = read;
		z80_mreq_n = 1'b0;
		n = 0;
		do begin
			@(negedge MCLK);
			n++;
		end while (!z80_wait_n && n < WAIT_LIMIT);
		if (!z80_wait_n)
			abort_run("sound CPU wait never released");
		rdata      = z80_rdata;
		va_seen    = va;
		z80_mreq_n = 1'b1;
		z80_rd_n   = 1'b1;
		z80_wr_n   = 1'b1;
		@(negedge MCLK);
	endtask

	// ------------------------------------------------
	// Directed tests
	// ------------------------------------------------
	task automatic reset_and_enables();
		int last_p;
		int last_z;
		int pulses_p;
		int pulses_z;
		@(negedge MCLK);
		if ({m68k_dtack_n, z80_wait_n, uds_n, lds_n, rnw, ram_ce_n, z80_busrq_n,
			z80_reset_n} !== 8'b1111_1110)
			report_error("outputs after reset", {m68k_dtack_n, z80_wait_n, uds_n, lds_n,
				rnw, ram_ce_n, z80_busrq_n, z80_reset_n}, 8'b1111_1110);
		last_p   = -1;
		last_z   = -1;
		pulses_p = 0;
		pulses_z = 0;
		for (int cyc = 0; cyc < 64; cyc++) begin
			@(negedge MCLK);
			if (m68k_ce_n && last_p >= 0 && cyc - last_p != 3)
				report_error("m68k_ce_n offset from m68k_ce_p", cyc - last_p, 3);
			if (m68k_ce_p) begin
				if (last_p >= 0 && cyc - last_p != 7)
					report_error("m68k_ce_p spacing", cyc - last_p, 7);
				last_p = cyc;
				pulses_p++;
			end
			if (z80_ce) begin
				if (last_z >= 0 && cyc - last_z != 15)
					report_error("z80_ce spacing", cyc - last_z, 15);
				last_z = cyc;
				pulses_z++;
			end
		end
		if (pulses_p < 9 || pulses_z < 4)
			report_error("clock enable pulse count", {pulses_p[15:0], pulses_z[15:0]},
				{16'd9, 16'd4});
	endtask

	task automatic rom_and_open_bus();
		logic [15:0] data;
		logic [23:1] seen;
		logic [15:0] lo_bits;
		logic [15:0] hi_bits;
		logic [23:0] addr;
		m68k_access(24'hC00004, 16'h0000, 1'b0, 2'b11, data, seen);
		if (data !== 16'h4E71)
			report_error("first open-bus read", data, 16'h4E71);
		if (last_latency != 3)
			report_error("unmapped dtack latency", last_latency, 3);
		take_bits(16, lo_bits);
		take_bits(5, hi_bits);
		addr = {2'b00, hi_bits[4:0], lo_bits, 1'b0};
		m68k_access(addr, 16'h0000, 1'b0, 2'b11, data, seen);
		if (data !== rom_word(addr))
			report_error("ROM read data", data, rom_word(addr));
		if (seen !== addr[23:1])
			report_error("ROM read va", seen, addr[23:1]);
		m68k_access(24'hA13000, 16'h0000, 1'b0, 2'b11, data, seen);
		if (data !== rom_word(addr))
			report_error("open bus after ROM read", data, rom_word(addr));
		open_bus_exp = rom_word(addr);
	endtask

	task automatic ram_byte_merge();
		logic [15:0] idx;
		logic [15:0] word;
		logic [15:0] data;
		logic [23:1] seen;
		logic [23:0] addr;
		for (int k = 0; k < 4; k++) begin
			take_bits(8, idx);
			take_bits(16, word);
			addr = 24'hFF0000 | {15'd0, idx[7:0], 1'b0};
			// Junk on the unused lane of each byte write
			m68k_access(addr, {word[15:8], ~word[15:8]}, 1'b1, 2'b10, data, seen);
			m68k_access(addr, {~word[7:0], word[7:0]}, 1'b1, 2'b01, data, seen);
			m68k_access(addr, 16'h0000, 1'b0, 2'b11, data, seen);
			if (data !== word)
				report_error("RAM merged word", data, word);
			open_bus_exp = word;
		end
	endtask

	task automatic ctrl_read(input logic [23:0] addr, input logic bit8);
		logic [15:0] exp;
		logic [15:0] data;
		logic [23:1] seen;
		exp = {open_bus_exp[15:9], bit8, open_bus_exp[7:0]};
		m68k_access(addr, 16'h0000, 1'b0, 2'b11, data, seen);
		if (data !== exp)
			report_error("control register read", data, exp);
		open_bus_exp = exp;
	endtask

	task automatic control_registers();
		logic [15:0] data;
		logic [23:1] seen;
		m68k_access(24'hA11100, 16'h0100, 1'b1, 2'b11, data, seen);
		if (z80_busrq_n !== 1'b0)
			report_error("z80_busrq_n after bus request set", z80_busrq_n, 0);
		if (last_latency != 3)
			report_error("control write dtack latency", last_latency, 3);
		m68k_access(24'hA11200, 16'h0100, 1'b1, 2'b11, data, seen);
		if (z80_reset_n !== 1'b1)
			report_error("z80_reset_n after reset release", z80_reset_n, 1);
		@(negedge MCLK);
		z80_busak_n = 1'b1;
		ctrl_read(24'hA11100, 1'b1);
		@(negedge MCLK);
		z80_busak_n = 1'b0;
		ctrl_read(24'hA11100, 1'b0);
		ctrl_read(24'hA11200, 1'b1);
		m68k_access(24'hA11200, 16'h0000, 1'b1, 2'b11, data, seen);
		if (z80_reset_n !== 1'b0)
			report_error("z80_reset_n after reset asserted", z80_reset_n, 0);
		ctrl_read(24'hA11200, 1'b0);
		// Sound CPU held in reset reads as not granted
		ctrl_read(24'hA11100, 1'b1);
		m68k_access(24'hA11100, 16'h0000, 1'b1, 2'b11, data, seen);
		if (z80_busrq_n !== 1'b1)
			report_error("z80_busrq_n after bus request cleared", z80_busrq_n, 1);
	endtask

	task automatic sound_window();
		logic [7:0]  bytes [0:3];
		logic [15:0] b;
		logic [15:0] data;
		logic [23:1] seen;
		logic [23:0] addr;
		m68k_access(24'hA11100, 16'h0100, 1'b1, 2'b11, data, seen);
		m68k_access(24'hA11200, 16'h0100, 1'b1, 2'b11, data, seen);
		for (int k = 0; k < 4; k++) begin
			take_bits(8, b);
			bytes[k] = b[7:0];
			addr = 24'hA00140 + k;
			m68k_access(addr, addr[0] ? {~b[7:0], b[7:0]} : {b[7:0], ~b[7:0]}, 1'b1,
				{~addr[0], addr[0]}, data, seen);
		end
		for (int k = 0; k < 4; k++) begin
			addr = 24'hA00140 + k;
			m68k_access(addr, 16'h0000, 1'b0, {~addr[0], addr[0]}, data, seen);
			if (lane_byte(data, addr[0]) !== bytes[k])
				report_error("granted window read", lane_byte(data, addr[0]), bytes[k]);
		end
		m68k_access(24'hA11100, 16'h0000, 1'b1, 2'b11, data, seen);
		for (int k = 0; k < 4; k++) begin
			addr = 24'hA00140 + k;
			m68k_access(addr, 16'h0000, 1'b0, {~addr[0], addr[0]}, data, seen);
			if (lane_byte(data, addr[0]) !== 8'hFF)
				report_error("window read without grant", lane_byte(data, addr[0]), 8'hFF);
			m68k_access(addr, {~bytes[k], ~bytes[k]}, 1'b1, {~addr[0], addr[0]}, data, seen);
		end
		m68k_access(24'hA11100, 16'h0100, 1'b1, 2'b11, data, seen);
		for (int k = 0; k < 4; k++) begin
			addr = 24'hA00140 + k;
			m68k_access(addr, 16'h0000, 1'b0, {~addr[0], addr[0]}, data, seen);
			if (lane_byte(data, addr[0]) !== bytes[k])
				report_error("RAM changed by ungranted write", lane_byte(data, addr[0]),
					bytes[k]);
		end
	endtask

	task automatic sound_cpu_bus();
		logic [7:0]  bytes [0:3];
		logic [15:0] b;
		logic [7:0]  data;
		logic [23:1] seen;
		logic [15:0] z_addr;
		logic [8:0]  bank_val;
		logic [15:0] word;
		for (int k = 0; k < 4; k++) begin
			take_bits(8, b);
			bytes[k] = b[7:0];
			z80_access(16'h0230 + k[15:0], b[7:0], 1'b0, data, seen);
		end
		for (int k = 0; k < 4; k++) begin
			z80_access(16'h0230 + k[15:0], 8'h00, 1'b1, data, seen);
			if (data !== bytes[k])
				report_error("sound RAM read", data, bytes[k]);
			// Upper 8 KB mirrors the lower
			z80_access(16'h2230 + k[15:0], 8'h00, 1'b1, data, seen);
			if (data !== bytes[k])
				report_error("sound RAM mirror read", data, bytes[k]);
		end
		z80_access(16'h7F10, 8'h00, 1'b1, data, seen);
		if (data !== 8'hFF)
			report_error("dropped 7F00 area read", data, 8'hFF);
		take_bits(7, b);
		bank_val = {2'b00, b[6:0]};
		for (int i = 0; i < 9; i++)
			z80_access(16'h6000, {7'd0, bank_val[i]}, 1'b0, data, seen);
		for (int n = 0; n < 4; n++) begin
			z_addr = 16'h8124 + n[15:0];
			word   = rom_word({bank_val, z_addr[14:0]});
			z80_access(z_addr, 8'h00, 1'b1, data, seen);
			if (seen !== {bank_val, z_addr[14:1]})
				report_error("banked va", seen, {bank_val, z_addr[14:1]});
			if (data !== lane_byte(word, z_addr[0]))
				report_error("banked read lane", data, lane_byte(word, z_addr[0]));
		end
	endtask

	initial begin
		int fails;
		errors      = 0;
		m68k_addr   = '0;
		m68k_wdata  = '0;
		m68k_as_n   = 1'b1;
		m68k_uds_n  = 1'b1;
		m68k_lds_n  = 1'b1;
		m68k_rnw    = 1'b1;
		z80_addr    = '0;
		z80_wdata   = '0;
		z80_mreq_n  = 1'b1;
		z80_rd_n    = 1'b1;
		z80_wr_n    = 1'b1;
		z80_busak_n = 1'b1;
		reset       = 1'b1;
		for (int i = 0; i < 5; i++) begin
			@(negedge MCLK);
			if (m68k_ce_p || m68k_ce_n || z80_ce)
				report_error("clock enable in reset", {m68k_ce_p, m68k_ce_n, z80_ce}, 0);
		end
		reset = 1'b0;

		reset_and_enables();
		rom_and_open_bus();
		ram_byte_merge();
		control_registers();
		sound_window();
		sound_cpu_bus();

		@(negedge MCLK);
		fails = genbus_top_inst.genbus_chk_inst.assert_fails;
		$display("Run complete: %0d check errors, %0d assertion failures", errors, fails);
		if (errors == 0 && fails == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verification/genbus_chk.sv ====
/*
 * Bus handshake checker
 * Bound into the system bus controller top level. Watches the
 * main CPU dtack release, the RAM select window and the sound
 * CPU control outputs right after reset
 */
`default_nettype none

module genbus_chk (
	input wire       MCLK,
	input wire       reset,
	input wire       m68k_as_n,
	input wire       m68k_dtack_n,
	input wire       ram_ce_n,
	input wire       z80_reset_n,
	input wire       z80_busrq_n,
	input wire [3:0] mbus_state
);

	int assert_fails = 0;

	// dtack follows the address strobe up within one cycle
	dtack_release: assert property (@(posedge MCLK) disable iff (reset)
		m68k_as_n [*2] |-> m68k_dtack_n)
	else begin
		assert_fails++;
		$error("dtack low with the address strobe high for two cycles");
	end

	// RAM select only in RAM wait, access and its closing state
	ram_select_window: assert property (@(posedge MCLK) disable iff (reset)
		!ram_ce_n |-> mbus_state inside {genbus_pkg::MBUS_RAM_WAIT,
			genbus_pkg::MBUS_RAM_READ, genbus_pkg::MBUS_RAM_WRITE, genbus_pkg::MBUS_FINISH})
	else begin
		assert_fails++;
		$error("ram_ce_n low outside a RAM cycle");
	end

	sound_cpu_held: assert property (@(posedge MCLK) reset |=> !z80_reset_n && z80_busrq_n)
	else begin
		assert_fails++;
		$error("sound CPU control outputs wrong after reset");
	end

endmodule

bind genbus_top genbus_chk genbus_chk_inst (
	.MCLK        (MCLK),
	.reset       (reset),
	.m68k_as_n   (m68k_as_n),
	.m68k_dtack_n(m68k_dtack_n),
	.ram_ce_n    (ram_ce_n),
	.z80_reset_n (z80_reset_n),
	.z80_busrq_n (z80_busrq_n),
	.mbus_state  (main_bus_arbiter_inst.state)
);

`default_nettype wire

// ==== rtl/genbus_top.sv ====
/*
 * System bus controller top level
 * Clock enables, main bus arbiter and sound bus arbiter
 * joined to the CPU and memory ports
 */
`default_nettype none

module genbus_top (
	input  wire                                MCLK,
	input  wire                                reset,
	input  wire  [genbus_pkg::MBUS_ADDR_W:1]   m68k_addr,
	input  wire  [genbus_pkg::MBUS_DATA_W-1:0] m68k_wdata,
	input  wire                                m68k_as_n,
	input  wire                                m68k_uds_n,
	input  wire                                m68k_lds_n,
	input  wire                                m68k_rnw,
	output wire  [genbus_pkg::MBUS_DATA_W-1:0] m68k_rdata,
	output wire                                m68k_dtack_n,
	input  wire  [15:0]                        z80_addr,
	input  wire  [7:0]                         z80_wdata,
	input  wire                                z80_mreq_n,
	input  wire                                z80_rd_n,
	input  wire                                z80_wr_n,
	input  wire                                z80_busak_n,
	output wire  [7:0]                         z80_rdata,
	output wire                                z80_wait_n,
	output wire                                z80_busrq_n,
	output wire                                z80_reset_n,
	output wire  [genbus_pkg::MBUS_ADDR_W:1]   va,
	output wire  [genbus_pkg::MBUS_DATA_W-1:0] vdo,
	input  wire  [genbus_pkg::MBUS_DATA_W-1:0] vdi,
	output wire                                rnw,
	output wire                                uds_n,
	output wire                                lds_n,
	output wire                                ram_ce_n,
	output wire                                rom_n,
	input  wire                                rom_dtack_n,
	input  wire                                ram_rdy,
	output wire                                m68k_ce_p,
	output wire                                m68k_ce_n,
	output wire                                z80_ce
);

	// Links between the two arbiters
	wire                                zbus_req;
	wire [genbus_pkg::ZBUS_ADDR_W-1:0] zbus_addr;
	wire [7:0]                         zbus_wdata;
	wire                               zbus_we;
	wire                               zbus_granted;
	wire                               zbus_ack;
	wire [7:0]                         zbus_rdata;
	wire [genbus_pkg::BANK_W-1:0]      bank;

	// Sound CPU returns from each side
	wire [7:0] z80_mbus_rdata;
	wire       z80_mbus_wait_n;
	wire [7:0] z80_zbus_rdata;
	wire       z80_zbus_wait_n;

	clock_enables clock_enables_inst (.*);

	main_bus_arbiter main_bus_arbiter_inst (.*);

	sound_bus_arbiter sound_bus_arbiter_inst (.*);

	// Address bit 15 picks which arbiter owns the sound CPU access
	assign z80_rdata  = z80_addr[15] ? z80_mbus_rdata : z80_zbus_rdata;
	assign z80_wait_n = z80_mbus_wait_n & z80_zbus_wait_n;

endmodule

`default_nettype wire

// ==== rtl/sound_bus_arbiter.sv ====
/*
 * Sound bus arbiter
 * Serves the main bus window and the sound CPU one access at a
 * time, main bus first. Holds the sound RAM and the serially
 * loaded bank register; other addresses read FFh
 */
`default_nettype none

module sound_bus_arbiter (
	input  wire                                MCLK,
	input  wire                                reset,
	input  wire                                zbus_req,
	input  wire  [genbus_pkg::ZBUS_ADDR_W-1:0] zbus_addr,
	input  wire  [7:0]                         zbus_wdata,
	input  wire                                zbus_we,
	input  wire                                zbus_granted,
	input  wire  [15:0]                        z80_addr,
	input  wire  [7:0]                         z80_wdata,
	input  wire                                z80_mreq_n,
	input  wire                                z80_rd_n,
	input  wire                                z80_wr_n,
	output logic                               zbus_ack,
	output logic [7:0]                         zbus_rdata,
	output logic [7:0]                         z80_zbus_rdata,
	output logic                               z80_zbus_wait_n,
	output logic [genbus_pkg::BANK_W-1:0]      bank
);

	genbus_pkg::zbus_state_t state;
	genbus_pkg::zbus_src_t   src;

	logic [genbus_pkg::ZBUS_ADDR_W-1:0] za;
	logic [7:0]                         zdo;
	logic                               zwe;
	logic                               z80_zsel;
	logic                               z80_ack;
	logic                               zram_sel;
	logic                               bank_sel;
	logic [7:0]                         zram_q;
	logic [7:0]                         zbus_di;

	// 7F00-7FFF is left here too and simply reads FFh
	assign z80_zsel = ~z80_mreq_n & (~z80_rd_n | ~z80_wr_n) & ~z80_addr[15];

	assign zram_sel = genbus_pkg::in_range(za, genbus_pkg::ZRAM_BASE, genbus_pkg::ZRAM_LAST);
	assign bank_sel = genbus_pkg::in_range(za, genbus_pkg::BANK_BASE, genbus_pkg::BANK_LAST);
	assign zbus_di  = zram_sel ? zram_q : 8'hFF;

	// 8 KB mirrored twice over 0000-3FFF
	sound_ram sound_ram_inst (
		.MCLK (MCLK),
		.addr (za[genbus_pkg::ZRAM_ADDR_W-1:0]),
		.wdata(zdo),
		.we   (zwe & zram_sel),
		.rdata(zram_q)
	);

	// ------------------------------------------------
	// Access FSM
	// ------------------------------------------------
	always_ff @(posedge MCLK) begin
		if (reset) begin
			state   <= genbus_pkg::ZBUS_IDLE;
			src     <= genbus_pkg::ZSRC_MBUS;
			zwe     <= 1'b0;
			z80_ack <= 1'b0;
		end else begin
			zwe <= 1'b0;
			if (!z80_zsel)
				z80_ack <= 1'b0;
			case (state)
				genbus_pkg::ZBUS_IDLE:
					if (zbus_req) begin
						src   <= genbus_pkg::ZSRC_MBUS;
						za    <= zbus_addr;
						zdo   <= zbus_wdata;
						zwe   <= zbus_we & zbus_granted;
						state <= genbus_pkg::ZBUS_ACCESS;
					end else if (z80_zsel && !z80_ack) begin
						src   <= genbus_pkg::ZSRC_Z80;
						za    <= z80_addr[genbus_pkg::ZBUS_ADDR_W-1:0];
						zdo   <= z80_wdata;
						zwe   <= ~z80_wr_n;
						state <= genbus_pkg::ZBUS_ACCESS;
					end
				genbus_pkg::ZBUS_ACCESS:
					state <= genbus_pkg::ZBUS_FINISH;
				genbus_pkg::ZBUS_FINISH: begin
					if (src == genbus_pkg::ZSRC_Z80) begin
						z80_zbus_rdata <= zbus_di;
						z80_ack        <= 1'b1;
					end
					state <= genbus_pkg::ZBUS_IDLE;
				end
				default: state <= genbus_pkg::ZBUS_IDLE;
			endcase
		end
	end

	// Bank loads one bit per write, LSB first into the top
	always_ff @(posedge MCLK) begin
		if (reset)
			bank <= '0;
		else if (zwe && bank_sel)
			bank <= {zdo[0], bank[genbus_pkg::BANK_W-1:1]};
	end

	assign zbus_ack        = (state == genbus_pkg::ZBUS_FINISH) && (src == genbus_pkg::ZSRC_MBUS);
	assign zbus_rdata      = zbus_granted ? zbus_di : 8'hFF;
	assign z80_zbus_wait_n = ~(z80_zsel & ~z80_ack);

endmodule

`default_nettype wire

// ==== rtl/main_bus_arbiter.sv ====
/*
 * Main bus arbiter
 * Takes one cycle from the main CPU or, at lower priority, the
 * sound CPU, decodes ROM, work RAM, sound CPU window and the
 * sound CPU control registers, and waits on the target device.
 * Unmapped reads return the last main CPU read data
 */
`default_nettype none

module main_bus_arbiter (
	input  wire                                   MCLK,
	input  wire                                   reset,
	input  wire  [genbus_pkg::MBUS_ADDR_W:1]      m68k_addr,
	input  wire  [genbus_pkg::MBUS_DATA_W-1:0]    m68k_wdata,
	input  wire                                   m68k_as_n,
	input  wire                                   m68k_uds_n,
	input  wire                                   m68k_lds_n,
	input  wire                                   m68k_rnw,
	output logic [genbus_pkg::MBUS_DATA_W-1:0]    m68k_rdata,
	output logic                                  m68k_dtack_n,
	input  wire  [15:0]                           z80_addr,
	input  wire  [7:0]                            z80_wdata,
	input  wire                                   z80_mreq_n,
	input  wire                                   z80_rd_n,
	input  wire                                   z80_wr_n,
	input  wire                                   z80_busak_n,
	output logic [7:0]                            z80_mbus_rdata,
	output logic                                  z80_mbus_wait_n,
	output logic                                  z80_busrq_n,
	output logic                                  z80_reset_n,
	input  wire  [genbus_pkg::MBUS_DATA_W-1:0]    vdi,
	input  wire                                   rom_dtack_n,
	input  wire                                   ram_rdy,
	output logic [genbus_pkg::MBUS_ADDR_W:1]      va,
	output logic [genbus_pkg::MBUS_DATA_W-1:0]    vdo,
	output logic                                  rnw,
	output logic                                  uds_n,
	output logic                                  lds_n,
	output logic                                  ram_ce_n,
	output logic                                  rom_n,
	input  wire  [genbus_pkg::BANK_W-1:0]         bank,
	input  wire                                   zbus_ack,
	input  wire  [7:0]                            zbus_rdata,
	output logic                                  zbus_req,
	output logic [genbus_pkg::ZBUS_ADDR_W-1:0]    zbus_addr,
	output logic [7:0]                            zbus_wdata,
	output logic                                  zbus_we,
	output logic                                  zbus_granted
);

	genbus_pkg::mbus_state_t state;
	genbus_pkg::mbus_src_t   src;

	logic [23:0] mbus_byte;
	logic        m68k_req;
	logic        z80_msel;
	logic        z80_mbus_ack;
	logic        rom_sel;
	logic        ram_sel;
	logic        is_busreq;
	logic        is_zreset;
	logic        ctrl_bit;
	logic        cycle_done;
	logic [15:0] done_data;
	logic [15:0] rdata_r;
	logic [15:0] open_bus;

	assign m68k_req = ~m68k_as_n & (~m68k_uds_n | ~m68k_lds_n);
	// Upper half of the sound CPU space is the banked main bus window
	assign z80_msel = ~z80_mreq_n & (~z80_rd_n | ~z80_wr_n) & z80_addr[15];

	assign mbus_byte = {va, 1'b0};
	assign is_busreq = (mbus_byte == genbus_pkg::BUSREQ_ADDR);
	assign is_zreset = (mbus_byte == genbus_pkg::ZRESET_ADDR);
	assign ctrl_bit  = is_busreq ? (z80_busak_n | ~z80_reset_n) : z80_reset_n;

	// ------------------------------------------------
	// Device completion and returned data
	// ------------------------------------------------
	always_comb begin
		cycle_done = 1'b0;
		done_data  = open_bus;
		case (state)
			genbus_pkg::MBUS_ROM_READ: begin
				cycle_done = ~rom_dtack_n;
				done_data  = vdi;
			end
			genbus_pkg::MBUS_RAM_READ: begin
				cycle_done = ram_rdy;
				done_data  = vdi;
			end
			genbus_pkg::MBUS_RAM_WRITE: cycle_done = 1'b1;
			genbus_pkg::MBUS_ZBUS_WAIT: begin
				cycle_done = zbus_ack;
				done_data  = {zbus_rdata, zbus_rdata};
			end
			genbus_pkg::MBUS_UNMAPPED: begin
				cycle_done = 1'b1;
				if (is_busreq || is_zreset)
					done_data = {open_bus[15:9], ctrl_bit, open_bus[7:0]};
			end
			default: ;
		endcase
	end

	always_ff @(posedge MCLK) begin
		if (reset) begin
			state        <= genbus_pkg::MBUS_IDLE;
			src          <= genbus_pkg::MSRC_NONE;
			m68k_dtack_n <= 1'b1;
			z80_mbus_ack <= 1'b0;
			rnw          <= 1'b1;
			uds_n        <= 1'b1;
			lds_n        <= 1'b1;
			rom_sel      <= 1'b0;
			ram_sel      <= 1'b0;
			zbus_req     <= 1'b0;
			z80_busrq_n  <= 1'b1;
			z80_reset_n  <= 1'b0;
			open_bus     <= genbus_pkg::OPEN_BUS_INIT;
		end else begin
			case (state)
				genbus_pkg::MBUS_IDLE: begin
					if (m68k_req) begin
						src   <= genbus_pkg::MSRC_M68K;
						va    <= m68k_addr;
						vdo   <= m68k_wdata;
						uds_n <= m68k_uds_n;
						lds_n <= m68k_lds_n;
						rnw   <= m68k_rnw;
						state <= genbus_pkg::MBUS_SELECT;
					end else if (z80_msel) begin
						// Even byte on the upper lane
						src   <= genbus_pkg::MSRC_Z80;
						va    <= {bank, z80_addr[14:1]};
						vdo   <= {z80_wdata, z80_wdata};
						uds_n <= z80_addr[0];
						lds_n <= ~z80_addr[0];
						rnw   <= z80_wr_n;
						state <= genbus_pkg::MBUS_SELECT;
					end
				end
				genbus_pkg::MBUS_SELECT: begin
					if (genbus_pkg::in_range(mbus_byte, genbus_pkg::ROM_BASE,
						genbus_pkg::ROM_LAST)) begin
						rom_sel <= 1'b1;
						state   <= genbus_pkg::MBUS_ROM_READ;
					end else if (genbus_pkg::in_range(mbus_byte, genbus_pkg::ZWIN_BASE,
						genbus_pkg::ZWIN_LAST)) begin
						zbus_req <= 1'b1;
						state    <= genbus_pkg::MBUS_ZBUS_WAIT;
					end else if (genbus_pkg::in_range(mbus_byte, genbus_pkg::RAM_BASE,
						genbus_pkg::RAM_LAST)) begin
						ram_sel <= 1'b1;
						state   <= genbus_pkg::MBUS_RAM_WAIT;
					end else begin
						state <= genbus_pkg::MBUS_UNMAPPED;
					end
				end
				genbus_pkg::MBUS_RAM_WAIT:
					if (!ram_rdy)
						state <= rnw ? genbus_pkg::MBUS_RAM_READ : genbus_pkg::MBUS_RAM_WRITE;
				genbus_pkg::MBUS_UNMAPPED:
					// Control bits sit on the upper data lane
					if (!rnw && !uds_n) begin
						if (is_busreq)
							z80_busrq_n <= ~vdo[8];
						if (is_zreset)
							z80_reset_n <= vdo[8];
					end
				genbus_pkg::MBUS_FINISH:
					if ((src == genbus_pkg::MSRC_M68K && m68k_as_n) ||
						(src == genbus_pkg::MSRC_Z80 && !z80_msel)) begin
						if (src == genbus_pkg::MSRC_M68K && rnw)
							open_bus <= rdata_r;
						m68k_dtack_n <= 1'b1;
						z80_mbus_ack <= 1'b0;
						rnw          <= 1'b1;
						uds_n        <= 1'b1;
						lds_n        <= 1'b1;
						rom_sel      <= 1'b0;
						ram_sel      <= 1'b0;
						src          <= genbus_pkg::MSRC_NONE;
						state        <= genbus_pkg::MBUS_IDLE;
					end
				default: ;
			endcase

			if (cycle_done) begin
				m68k_dtack_n <= (src != genbus_pkg::MSRC_M68K);
				z80_mbus_ack <= (src == genbus_pkg::MSRC_Z80);
				zbus_req     <= 1'b0;
				state        <= genbus_pkg::MBUS_FINISH;
			end
		end
	end

	// Read data register, no reset needed
	always_ff @(posedge MCLK) begin
		if (cycle_done)
			rdata_r <= done_data;
	end

	assign m68k_rdata      = rdata_r;
	assign z80_mbus_rdata  = z80_addr[0] ? rdata_r[7:0] : rdata_r[15:8];
	assign z80_mbus_wait_n = ~(z80_msel & ~z80_mbus_ack);

	assign ram_ce_n = ~ram_sel;
	assign rom_n    = ~rom_sel;

	// Sound bus byte view of the latched cycle
	assign zbus_addr    = {va[14:1], uds_n};
	assign zbus_wdata   = uds_n ? vdo[7:0] : vdo[15:8];
	assign zbus_we      = ~rnw;
	assign zbus_granted = ~z80_busrq_n & z80_reset_n;

endmodule

`default_nettype wire

// ==== rtl/sound_ram.sv ====
/*
 * Sound CPU work RAM
 * Single-port byte RAM, one cycle read latency
 */
`default_nettype none

module sound_ram (
	input  wire                                MCLK,
	input  wire  [genbus_pkg::ZRAM_ADDR_W-1:0] addr,
	input  wire  [7:0]                         wdata,
	input  wire                                we,
	output logic [7:0]                         rdata
);

	logic [7:0] mem [0:(2**genbus_pkg::ZRAM_ADDR_W)-1];

	// Read returns the old byte on a write
	always_ff @(posedge MCLK) begin
		if (we)
			mem[addr] <= wdata;
		rdata <= mem[addr];
	end

endmodule

`default_nettype wire

// ==== rtl/clock_enables.sv ====
/*
 * Clock enable divider
 * Two-phase enables for the main CPU and a single enable
 * for the sound CPU, all held low in reset
 */
`default_nettype none

module clock_enables (
	input  wire  MCLK,
	input  wire  reset,
	output logic m68k_ce_p,
	output logic m68k_ce_n,
	output logic z80_ce
);

	logic [$clog2(genbus_pkg::M68K_CE_PERIOD)-1:0] m68k_cnt;
	logic [$clog2(genbus_pkg::Z80_CE_PERIOD)-1:0]  z80_cnt;

	always_ff @(posedge MCLK) begin
		if (reset) begin
			m68k_cnt  <= '0;
			z80_cnt   <= '0;
			m68k_ce_p <= 1'b0;
			m68k_ce_n <= 1'b0;
			z80_ce    <= 1'b0;
		end else begin
			// Phase 1 lands on count 0, phase 2 on the N point
			if (m68k_cnt == genbus_pkg::M68K_CE_PERIOD - 1)
				m68k_cnt <= '0;
			else
				m68k_cnt <= m68k_cnt + 1'b1;
			m68k_ce_p <= (m68k_cnt == genbus_pkg::M68K_CE_PERIOD - 1);
			m68k_ce_n <= (m68k_cnt == genbus_pkg::M68K_CE_N_POINT - 1);

			if (z80_cnt == genbus_pkg::Z80_CE_PERIOD - 1)
				z80_cnt <= '0;
			else
				z80_cnt <= z80_cnt + 1'b1;
			z80_ce <= (z80_cnt == genbus_pkg::Z80_CE_PERIOD - 1);
		end
	end

endmodule

`default_nettype wire

// ==== rtl/genbus_pkg.sv ====
/*
 * System bus controller shared definitions
 * Bus widths, clock enable periods, open-bus reset value,
 * main bus and sound bus address regions, FSM state enums
 */
`default_nettype none

package genbus_pkg;

	// Widths
	localparam int MBUS_ADDR_W = 23;
	localparam int MBUS_DATA_W = 16;
	localparam int ZBUS_ADDR_W = 15;
	localparam int ZRAM_ADDR_W = 13;
	localparam int BANK_W      = 9;

	// Clock enable dividers
	localparam int M68K_CE_PERIOD  = 7;
	localparam int M68K_CE_N_POINT = 3;
	localparam int Z80_CE_PERIOD   = 15;

	localparam logic [15:0] OPEN_BUS_INIT = 16'h4E71;

	// ------------------------------------------------
	// Main bus regions, byte addresses
	// ------------------------------------------------
	localparam logic [23:0] ROM_BASE    = 24'h000000;
	localparam logic [23:0] ROM_LAST    = 24'h3FFFFF;
	localparam logic [23:0] ZWIN_BASE   = 24'hA00000;
	localparam logic [23:0] ZWIN_LAST   = 24'hA0FFFF;
	localparam logic [23:0] BUSREQ_ADDR = 24'hA11100;
	localparam logic [23:0] ZRESET_ADDR = 24'hA11200;
	localparam logic [23:0] RAM_BASE    = 24'hE00000;
	localparam logic [23:0] RAM_LAST    = 24'hFFFFFF;

	// Sound bus regions
	localparam logic [15:0] ZRAM_BASE = 16'h0000;
	localparam logic [15:0] ZRAM_LAST = 16'h3FFF;
	localparam logic [15:0] BANK_BASE = 16'h6000;
	localparam logic [15:0] BANK_LAST = 16'h60FF;

	typedef enum logic [3:0] {
		MBUS_IDLE, MBUS_SELECT, MBUS_ROM_READ, MBUS_RAM_WAIT, MBUS_RAM_READ,
		MBUS_RAM_WRITE, MBUS_ZBUS_WAIT, MBUS_UNMAPPED, MBUS_FINISH
	} mbus_state_t;

	typedef enum logic [1:0] {MSRC_NONE, MSRC_M68K, MSRC_Z80} mbus_src_t;

	typedef enum logic [1:0] {ZBUS_IDLE, ZBUS_ACCESS, ZBUS_FINISH} zbus_state_t;

	typedef enum logic {ZSRC_MBUS, ZSRC_Z80} zbus_src_t;

	function automatic logic in_range(logic [23:0] addr, logic [23:0] lo, logic [23:0] hi);
		return (addr >= lo) && (addr <= hi);
	endfunction

endpackage

`default_nettype wire
